/* filelist.f */
verilog/serial_link_cfg_pkg.sv
verilog/serial_link_flit_pkg.sv
verilog/serial_link_phy_tx.sv
verilog/serial_link_tx_alloc.sv
verilog/serial_link_phy_rx.sv
verilog/serial_link_rx_alloc.sv
verilog/serial_link.sv
testbench/tb_clk_gen.sv
testbench/tb_serial_link.sv

/* Bender.yml */
package:
  name: serial_link

sources:
  # Packages first, then leaf modules up to the top level
  - verilog/serial_link_cfg_pkg.sv
  - verilog/serial_link_flit_pkg.sv
  - verilog/serial_link_phy_tx.sv
  - verilog/serial_link_tx_alloc.sv
  - verilog/serial_link_phy_rx.sv
  - verilog/serial_link_rx_alloc.sv
  - verilog/serial_link.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_serial_link.sv

/* testbench/tb_serial_link.sv */
/*
  Loopback testbench for the serial link. Channel 1 runs through a delay
  line with a per-test tap; concurrent assertions check the handshake,
  the forwarded clocks and every received flit against a scoreboard.
*/
`timescale 1ns/1ps

module tb_serial_link;

  import serial_link_cfg_pkg::*;
  import serial_link_flit_pkg::*;

  localparam int ChunkBits     = FlitBits / NumChannels;
  localparam int BeatsPerChunk = ChunkBits / NumLanes;
  localparam int FlitCycles    = BeatsPerChunk * ClkDiv;
  localparam int ClkPeriodNs   = 4;
  localparam int ResetCycles   = 8;
  localparam logic [31:0] Seed = 32'h7526;
  localparam int MaxSkew       = 6;
  localparam int MaxGap        = 3;
  localparam int QuietCycles   = 12;
  localparam int NumTests      = 6;
  localparam int StreamFlits   = 50;
  localparam int HeldFlits     = 4;
  localparam int PressureFlits = 3;
  localparam int SkewFlits     = 20;
  localparam int TotalFlits    = 1 + StreamFlits + HeldFlits + PressureFlits + SkewFlits;
  localparam int DrainLimit    = 4 * (FlitCycles + 1) + MaxSkew + 20;
  localparam int WatchdogCycles = TotalFlits * (FlitCycles + 1 + MaxGap) + MaxSkew
                                + NumTests * (DrainLimit + QuietCycles) + ResetCycles + 200;

  logic                                 clk;
  logic                                 arst_n;
  flit_t                                tx_flit;
  logic                                 tx_valid;
  logic                                 tx_ready;
  flit_t                                rx_flit;
  logic                                 rx_valid;
  logic [NumChannels-1:0]               phy_clk_tx;
  logic [NumChannels-1:0]               phy_clk_rx;
  logic [NumChannels-1:0][NumLanes-1:0] phy_data_tx;
  logic [NumChannels-1:0][NumLanes-1:0] phy_data_rx;

  logic [MaxSkew-1:0][NumLanes:0] dly_q;
  int                             skew;
  flit_t                          exp_q[$];
  flit_t                          exp_head;
  int                             exp_cnt;
  int                             n_sent;
  int                             n_recv;
  int                             refused;
  logic                           seen_accept;
  logic                           m_full;
  int                             m_busy;
  int                             errors;
  int                             tests_passed;
  int                             tests_failed;

  tb_clk_gen #(
    .PeriodNs    ( ClkPeriodNs ),
    .ResetCycles ( ResetCycles )
  ) i_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  serial_link dut (
    .clk_i      ( clk         ),
    .arst_n_i   ( arst_n      ),
    .tx_flit_i  ( tx_flit     ),
    .tx_valid_i ( tx_valid    ),
    .tx_ready_o ( tx_ready    ),
    .rx_flit_o  ( rx_flit     ),
    .rx_valid_o ( rx_valid    ),
    .phy_clk_o  ( phy_clk_tx  ),
    .phy_clk_i  ( phy_clk_rx  ),
    .phy_data_o ( phy_data_tx ),
    .phy_data_i ( phy_data_rx )
  );

  //////////////////////////////
  // Loopback with skew
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dly_q <= '0;
    end else begin
      dly_q <= {dly_q[MaxSkew-2:0], phy_clk_tx[1], phy_data_tx[1]};
    end
  end

  // Channel 1 clock and lanes share one tap so they stay aligned
  always_comb begin
    phy_clk_rx  = phy_clk_tx;
    phy_data_rx = phy_data_tx;
    if (skew > 0) begin
      {phy_clk_rx[1], phy_data_rx[1]} = dly_q[skew-1];
    end
  end

  //////////////////////////////
  // Scoreboard and models
  //////////////////////////////

  always @(posedge clk) begin
    if (arst_n) begin
      if (tx_valid && tx_ready) begin
        exp_q.push_back(tx_flit);
        n_sent++;
        seen_accept <= 1'b1;
      end
      if (tx_valid && !tx_ready) begin
        refused++;
      end
      if (rx_valid) begin
        n_recv++;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
    end
    exp_cnt  <= exp_q.size();
    exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  // Slot is full from accept until all channels are free, then busy for one chunk
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_full <= 1'b0;
      m_busy <= 0;
    end else if (m_full && m_busy == 0) begin
      m_full <= 1'b0;
      m_busy <= FlitCycles;
    end else begin
      if (m_busy != 0) begin
        m_busy <= m_busy - 1;
      end
      if (tx_valid && tx_ready) begin
        m_full <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  assert property (@(posedge clk) disable iff (!arst_n)
    !seen_accept |-> tx_ready && !rx_valid && phy_clk_tx == '0 && phy_data_tx == '0)
  else begin
    $display("Link was not quiet before the first accept at %0t ns", $time);
    errors++;
  end

  assert property (@(posedge clk) disable iff (!arst_n) tx_ready == !m_full)
  else begin
    $display("Mismatch at %0t ns: tx_ready_o expected %b got %b",
             $time, !$sampled(m_full), $sampled(tx_ready));
    errors++;
  end

  assert property (@(posedge clk) disable iff (!arst_n) rx_valid |-> exp_cnt != 0)
  else begin
    $display("Unexpected rx_valid_o pulse at %0t ns with no flit outstanding", $time);
    errors++;
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    rx_valid && exp_cnt != 0 |-> rx_flit == exp_head)
  else begin
    $display("Mismatch at %0t ns: rx_flit_o expected %h got %h",
             $time, $sampled(exp_head), $sampled(rx_flit));
    errors++;
  end

  for (genvar c = 0; c < NumChannels; c++) begin : gen_clk_chk
    logic clk_d;
    int   rise_cnt;
    int   since_rise;

    // Rises in the current chunk and cycles since the last one
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        clk_d      <= 1'b0;
        rise_cnt   <= 0;
        since_rise <= 0;
      end else begin
        clk_d <= phy_clk_tx[c];
        if (phy_clk_tx[c] && !clk_d) begin
          rise_cnt   <= rise_cnt + 1;
          since_rise <= 1;
        end else begin
          if (since_rise < 1000) begin
            since_rise <= since_rise + 1;
          end
          if (rise_cnt == BeatsPerChunk && since_rise >= ClkDiv) begin
            rise_cnt <= 0;
          end
        end
      end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
      $rose(phy_clk_tx[c]) && rise_cnt != 0 |-> since_rise == ClkDiv)
    else begin
      $display("Mismatch at %0t ns: phy_clk_o[%0d] rise spacing expected %0d got %0d",
               $time, c, ClkDiv, $sampled(since_rise));
      errors++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
      $rose(phy_clk_tx[c]) |-> rise_cnt < BeatsPerChunk)
    else begin
      $display("phy_clk_o[%0d] rose more than %0d times for one chunk at %0t ns",
               c, BeatsPerChunk, $time);
      errors++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
      rise_cnt != 0 && rise_cnt < BeatsPerChunk |-> since_rise <= ClkDiv)
    else begin
      $display("phy_clk_o[%0d] stopped after %0d of %0d beats at %0t ns",
               c, $sampled(rise_cnt), BeatsPerChunk, $time);
      errors++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
      $fell(phy_clk_tx[c]) && rise_cnt == BeatsPerChunk |-> phy_data_tx[c] == '0)
    else begin
      $display("Mismatch at %0t ns: phy_data_o[%0d] expected %h got %h",
               $time, c, {NumLanes{1'b0}}, $sampled(phy_data_tx[c]));
      errors++;
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  function automatic flit_t random_flit();
    return flit_t'($urandom());
  endfunction

  // Starts and ends 1 ns after a rising edge; valid stays high for back-to-back use
  task automatic send_flit(input flit_t flit, input int gap);
    int waited;
    waited = 0;
    if (gap > 0) begin
      tx_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    tx_flit  = flit;
    tx_valid = 1'b1;
    @(posedge clk);
    while (!tx_ready && waited < DrainLimit) begin
      @(posedge clk);
      waited++;
    end
    #1;
    if (waited >= DrainLimit) begin
      $display("tx_ready_o never rose for a pending flit by %0t ns", $time);
      errors++;
      tx_valid = 1'b0;
    end
  endtask

  task automatic send_stream(input int count, input int max_gap);
    for (int i = 0; i < count; i++) begin
      send_flit(random_flit(), $urandom_range(max_gap, 0));
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited   = 0;
    tx_valid = 1'b0;
    while (exp_q.size() != 0 && waited < DrainLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("Timed out at %0t ns with %0d flits never received", $time, exp_q.size());
      errors++;
    end
    // Let the delay line empty before a tap change
    repeat (QuietCycles) begin
      @(posedge clk);
      #1;
    end
    assert (n_recv == n_sent) else begin
      $display("Mismatch at %0t ns: rx_valid_o pulses expected %0d got %0d",
               $time, n_sent, n_recv);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("[%0t ns] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t ns] %s: failed with %0d errors", $time, name, errors - errs_before);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int errs;
    int ref_before;
    tx_flit      = '0;
    tx_valid     = 1'b0;
    skew         = 0;
    errors       = 0;
    n_sent       = 0;
    n_recv       = 0;
    refused      = 0;
    seen_accept  = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(Seed));
    wait (arst_n === 1'b1);

    errs = errors;
    repeat (QuietCycles) begin
      @(posedge clk);
      #1;
    end
    report_test("reset state", errs);

    errs = errors;
    send_flit('{tag: 8'hA5, payload: 24'h3C1E0F}, 0);
    wait_drain();
    report_test("single flit", errs);

    errs = errors;
    send_stream(StreamFlits, MaxGap);
    wait_drain();
    report_test("random stream", errs);

    // Valid held high across all flits
    errs = errors;
    send_stream(HeldFlits, 0);
    wait_drain();
    report_test("forwarded clock beats", errs);

    errs       = errors;
    ref_before = refused;
    send_flit(random_flit(), 0);
    send_flit(random_flit(), 2);
    send_flit(random_flit(), 0);
    wait_drain();
    assert (refused > ref_before) else begin
      $display("Back-pressure never appeared while a flit was waiting");
      errors++;
    end
    report_test("back-pressure", errs);

    errs = errors;
    skew = $urandom_range(MaxSkew, 1);
    send_stream(SkewFlits, MaxGap);
    wait_drain();
    report_test($sformatf("skewed stream, skew %0d", skew), errs);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriodNs);
    $display("Watchdog expired after %0d cycles before the tests finished", WatchdogCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule : tb_serial_link

/* testbench/tb_clk_gen.sv */
/*
  Free-running testbench clock and an active-low reset that is held for
  a fixed number of cycles and released just after a rising edge.
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PeriodNs    = 4,
  parameter int ResetCycles = 8
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Release lands 1 ns after an edge, like all other stimulus
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

/* verilog/serial_link.sv */
/*
  Serial link top level. Connects the transmit allocator, one receiver
  per channel and the receive allocator; loop phy outputs back for test.
*/
`timescale 1ns/1ps

module serial_link #(
  parameter int NumChannels = serial_link_cfg_pkg::NumChannels,
  parameter int NumLanes    = serial_link_cfg_pkg::NumLanes,
  parameter int ClkDiv      = serial_link_cfg_pkg::ClkDiv,
  localparam int ChunkBits  = serial_link_cfg_pkg::FlitBits / NumChannels
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  serial_link_flit_pkg::flit_t          tx_flit_i,
  input  logic                                 tx_valid_i,
  output logic                                 tx_ready_o,
  output serial_link_flit_pkg::flit_t          rx_flit_o,
  output logic                                 rx_valid_o,
  output logic [NumChannels-1:0]               phy_clk_o,
  input  logic [NumChannels-1:0]               phy_clk_i,
  output logic [NumChannels-1:0][NumLanes-1:0] phy_data_o,
  input  logic [NumChannels-1:0][NumLanes-1:0] phy_data_i
);

  logic [NumChannels-1:0][ChunkBits-1:0] rx_chunk;
  logic [NumChannels-1:0]                rx_chunk_valid;

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  serial_link_tx_alloc #(
    .NumChannels ( NumChannels ),
    .NumLanes    ( NumLanes    ),
    .ClkDiv      ( ClkDiv      )
  ) i_tx_alloc (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .tx_flit_i  ( tx_flit_i  ),
    .tx_valid_i ( tx_valid_i ),
    .tx_ready_o ( tx_ready_o ),
    .phy_clk_o  ( phy_clk_o  ),
    .phy_data_o ( phy_data_o )
  );

  //////////////////////////////
  // Receive path
  //////////////////////////////

  for (genvar c = 0; c < NumChannels; c++) begin : gen_phy_rx
    serial_link_phy_rx #(
      .NumLanes  ( NumLanes  ),
      .ChunkBits ( ChunkBits )
    ) i_phy_rx (
      .clk_i         ( clk_i             ),
      .arst_n_i      ( arst_n_i          ),
      .phy_clk_i     ( phy_clk_i[c]      ),
      .phy_data_i    ( phy_data_i[c]     ),
      .chunk_o       ( rx_chunk[c]       ),
      .chunk_valid_o ( rx_chunk_valid[c] )
    );
  end

  serial_link_rx_alloc #(
    .NumChannels ( NumChannels )
  ) i_rx_alloc (
    .clk_i         ( clk_i          ),
    .arst_n_i      ( arst_n_i       ),
    .chunk_i       ( rx_chunk       ),
    .chunk_valid_i ( rx_chunk_valid ),
    .rx_flit_o     ( rx_flit_o      ),
    .rx_valid_o    ( rx_valid_o     )
  );

endmodule : serial_link

/* verilog/serial_link_rx_alloc.sv */
/*
  Receive allocator. Keeps the latest chunk of every channel and releases
  the whole flit as a one-cycle pulse once all channels have delivered.
*/
`timescale 1ns/1ps

module serial_link_rx_alloc #(
  parameter int NumChannels = serial_link_cfg_pkg::NumChannels,
  localparam int ChunkBits = serial_link_cfg_pkg::FlitBits / NumChannels
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [NumChannels-1:0][ChunkBits-1:0] chunk_i,
  input  logic [NumChannels-1:0]                chunk_valid_i,
  output serial_link_flit_pkg::flit_t           rx_flit_o,
  output logic                                  rx_valid_o
);

  import serial_link_flit_pkg::*;

  logic [NumChannels-1:0][ChunkBits-1:0] buf_q;
  logic [NumChannels-1:0]                held_q;
  logic                                  all_held;
  flit_t                                 flit_q;
  logic                                  valid_q;

  assign all_held = &held_q;

  //////////////////////////////
  // Chunk buffers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < NumChannels; c++) begin
      if (chunk_valid_i[c]) begin
        buf_q[c] <= chunk_i[c];
      end
    end
  end

  // A chunk arriving in the combine cycle already belongs to the next flit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      held_q <= '0;
    end else if (all_held) begin
      held_q <= chunk_valid_i;
    end else begin
      held_q <= held_q | chunk_valid_i;
    end
  end

  //////////////////////////////
  // Flit output
  //////////////////////////////

  // Channel 0 fills the LSBs, matching the transmit split
  always_ff @(posedge clk_i) begin
    if (all_held) begin
      flit_q <= flit_t'(buf_q);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= all_held;
    end
  end

  assign rx_flit_o  = flit_q;
  assign rx_valid_o = valid_q;

endmodule : serial_link_rx_alloc

/* verilog/serial_link_phy_rx.sv */
/*
  Receive side of one channel. Brings the forwarded clock and lanes into
  clk_i, samples on each rising edge and collects one chunk.
*/
`timescale 1ns/1ps

module serial_link_phy_rx #(
  parameter int NumLanes  = serial_link_cfg_pkg::NumLanes,
  parameter int ChunkBits = serial_link_cfg_pkg::FlitBits / serial_link_cfg_pkg::NumChannels
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 phy_clk_i,
  input  logic [NumLanes-1:0]  phy_data_i,
  output logic [ChunkBits-1:0] chunk_o,
  output logic                 chunk_valid_o
);

  localparam int BeatsPerChunk = ChunkBits / NumLanes;
  localparam int BeatW = (BeatsPerChunk > 1) ? $clog2(BeatsPerChunk) : 1;
  localparam logic [BeatW-1:0] LastBeat = BeatW'(BeatsPerChunk - 1);

  logic                          clk_s1_q;
  logic                          clk_s2_q;
  logic                          clk_s3_q;
  logic [NumLanes-1:0]           data_s1_q;
  logic [NumLanes-1:0]           data_s2_q;
  logic                          rise;
  logic [BeatW-1:0]              beat_q;
  logic [ChunkBits-1:0]          chunk_q;
  logic [ChunkBits+NumLanes-1:0] shift_in;
  logic                          valid_q;

  //////////////////////////////
  // Synchronizer
  //////////////////////////////

  // Clock and data take the same two stages so they stay aligned
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_s1_q <= 1'b0;
      clk_s2_q <= 1'b0;
      clk_s3_q <= 1'b0;
    end else begin
      clk_s1_q <= phy_clk_i;
      clk_s2_q <= clk_s1_q;
      clk_s3_q <= clk_s2_q;
    end
  end

  always_ff @(posedge clk_i) begin
    data_s1_q <= phy_data_i;
    data_s2_q <= data_s1_q;
  end

  // Third clock stage only serves edge detection
  assign rise = clk_s2_q & ~clk_s3_q;

  //////////////////////////////
  // Deserializer
  //////////////////////////////

  // New lane word enters at the top, first word ends up in the LSBs
  assign shift_in = {data_s2_q, chunk_q};

  always_ff @(posedge clk_i) begin
    if (rise) begin
      chunk_q <= shift_in[ChunkBits+NumLanes-1:NumLanes];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= rise && (beat_q == LastBeat);
      if (rise) begin
        if (beat_q == LastBeat) begin
          beat_q <= '0;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
    end
  end

  assign chunk_o       = chunk_q;
  assign chunk_valid_o = valid_q;

endmodule : serial_link_phy_rx

/* verilog/serial_link_tx_alloc.sv */
/*
  Transmit allocator. Stages one flit, splits it into equal chunks and
  starts every channel serializer in the same cycle once all are idle.
*/
`timescale 1ns/1ps

module serial_link_tx_alloc #(
  parameter int NumChannels = serial_link_cfg_pkg::NumChannels,
  parameter int NumLanes    = serial_link_cfg_pkg::NumLanes,
  parameter int ClkDiv      = serial_link_cfg_pkg::ClkDiv
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  serial_link_flit_pkg::flit_t          tx_flit_i,
  input  logic                                 tx_valid_i,
  output logic                                 tx_ready_o,
  output logic [NumChannels-1:0]               phy_clk_o,
  output logic [NumChannels-1:0][NumLanes-1:0] phy_data_o
);

  import serial_link_cfg_pkg::*;
  import serial_link_flit_pkg::*;

  localparam int ChunkBits = FlitBits / NumChannels;

  flit_t                  slot_q;
  logic                   full_q;
  logic                   accept;
  logic                   start;
  logic [NumChannels-1:0] idle;

  //////////////////////////////
  // Staging slot
  //////////////////////////////

  assign tx_ready_o = ~full_q;
  assign accept     = tx_valid_i & ~full_q;

  // All chunks of a flit leave in step, so wait for every channel
  assign start = full_q & (&idle);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (start) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_q <= tx_flit_i;
    end
  end

  //////////////////////////////
  // Channel serializers
  //////////////////////////////

  for (genvar c = 0; c < NumChannels; c++) begin : gen_phy_tx
    serial_link_phy_tx #(
      .NumLanes  ( NumLanes  ),
      .ClkDiv    ( ClkDiv    ),
      .ChunkBits ( ChunkBits )
    ) i_phy_tx (
      .clk_i      ( clk_i                              ),
      .arst_n_i   ( arst_n_i                           ),
      .start_i    ( start                              ),
      .chunk_i    ( slot_q[c*ChunkBits +: ChunkBits]   ),
      .idle_o     ( idle[c]                            ),
      .phy_clk_o  ( phy_clk_o[c]                       ),
      .phy_data_o ( phy_data_o[c]                      )
    );
  end

endmodule : serial_link_tx_alloc

/* verilog/serial_link_phy_tx.sv */
/*
  Transmit side of one channel. Loads a chunk on start, drives one lane
  word per beat and forwards a clock that is high in each beat's second half.
*/
`timescale 1ns/1ps

module serial_link_phy_tx #(
  parameter int NumLanes  = serial_link_cfg_pkg::NumLanes,
  parameter int ClkDiv    = serial_link_cfg_pkg::ClkDiv,
  parameter int ChunkBits = serial_link_cfg_pkg::FlitBits / serial_link_cfg_pkg::NumChannels
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic [ChunkBits-1:0] chunk_i,
  output logic                 idle_o,
  output logic                 phy_clk_o,
  output logic [NumLanes-1:0]  phy_data_o
);

  import serial_link_flit_pkg::*;

  localparam int BeatsPerChunk = ChunkBits / NumLanes;
  localparam int CycW = $clog2(ClkDiv);
  localparam int BeatW = (BeatsPerChunk > 1) ? $clog2(BeatsPerChunk) : 1;

  // Clock rises after the cycle that ends the first half of a beat
  localparam logic [CycW-1:0] HalfCyc = CycW'(ClkDiv / 2 - 1);
  localparam logic [CycW-1:0] LastCyc = CycW'(ClkDiv - 1);
  localparam logic [BeatW-1:0] LastBeat = BeatW'(BeatsPerChunk - 1);

  phy_tx_state_e        state_q;
  logic [CycW-1:0]      cyc_q;
  logic [BeatW-1:0]     beat_q;
  logic [ChunkBits-1:0] shift_q;
  logic                 clk_q;
  logic [NumLanes-1:0]  data_q;
  logic                 load;
  logic                 beat_end;

  assign load     = (state_q == IDLE) && start_i;
  assign beat_end = (state_q == SHIFT) && (cyc_q == LastCyc);

  //////////////////////////////
  // Beat and chunk sequencing
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      cyc_q   <= '0;
      beat_q  <= '0;
      clk_q   <= 1'b0;
      data_q  <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= SHIFT;
            cyc_q   <= '0;
            beat_q  <= '0;
            clk_q   <= 1'b0;
            // First lane word goes out with the first beat
            data_q  <= chunk_i[NumLanes-1:0];
          end
        end
        SHIFT: begin
          if (beat_end) begin
            cyc_q <= '0;
            clk_q <= 1'b0;
            if (beat_q == LastBeat) begin
              // Line returns to all zero between chunks
              state_q <= IDLE;
              data_q  <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;
              data_q <= shift_q[NumLanes-1:0];
            end
          end else begin
            cyc_q <= cyc_q + 1'b1;
            if (cyc_q == HalfCyc) begin
              clk_q <= 1'b1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Remaining lane words, next one always in the low bits
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= chunk_i >> NumLanes;
    end else if (beat_end) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

  assign idle_o     = (state_q == IDLE);
  assign phy_clk_o  = clk_q;
  assign phy_data_o = data_q;

endmodule : serial_link_phy_tx

/* verilog/serial_link_flit_pkg.sv */
/*
  Flit format and the state encoding of the transmit serializer.
  Widths come from the link configuration package.
*/
package serial_link_flit_pkg;

  import serial_link_cfg_pkg::*;

  //////////////////////////////
  // Flit fields
  //////////////////////////////

  // Routing or message tag, carried in the upper flit bits
  typedef logic [TagBits-1:0] tag_t;

  // Data carried with the tag
  typedef logic [PayloadBits-1:0] payload_t;

  // Tag sits in the MSBs, so chunk 0 starts in the payload
  typedef struct packed {
    tag_t     tag;
    payload_t payload;
  } flit_t;

  //////////////////////////////
  // Serializer states
  //////////////////////////////

  // IDLE waits for a start pulse, SHIFT drives the beats of one chunk
  typedef enum logic {
    IDLE  = 1'b0,
    SHIFT = 1'b1
  } phy_tx_state_e;

endpackage : serial_link_flit_pkg

/* verilog/serial_link_cfg_pkg.sv */
/*
  Link dimensions of the serial link and the default values that the
  top level hands down as module parameters.
*/
package serial_link_cfg_pkg;

  //////////////////////////////
  // Link geometry
  //////////////////////////////

  // Channels that carry one flit side by side
  localparam int NumChannels = 2;

  // Single-data-rate lanes per channel
  localparam int NumLanes = 4;

  // clk_i cycles per beat on the wire
  // Must be even and at least 4 so the receiver synchronizer sees
  // both clock phases
  localparam int ClkDiv = 4;

  //////////////////////////////
  // Flit format
  //////////////////////////////

  localparam int TagBits = 8;
  localparam int PayloadBits = 24;

  // Whole flit as seen on the transmit and receive ports
  localparam int FlitBits = TagBits + PayloadBits;

endpackage : serial_link_cfg_pkg
